/* logic/sys_bus_pkg.sv */
// ######################################################################
// shared constants and state types for the data-side system bus
// import by wildcard in the module header
// ######################################################################
package sys_bus_pkg;

    // data and address width
    localparam int xlen = 32;

    // region map, bounds inclusive
    localparam logic [xlen-1:0] timer_base = 32'h0200_0000;
    localparam logic [xlen-1:0] timer_end  = 32'h0200_000f;
    localparam logic [xlen-1:0] int_base   = 32'h0200_1000;
    localparam logic [xlen-1:0] int_end    = 32'h0200_100f;

    // timer register offsets
    localparam logic [3:0] off_mtime_lo = 4'd0;
    localparam logic [3:0] off_mtime_hi = 4'd4;
    localparam logic [3:0] off_cmp_lo   = 4'd8;
    localparam logic [3:0] off_cmp_hi   = 4'd12;

    // interrupt region offset
    localparam logic [3:0] off_int_code = 4'd0;

    localparam int                        int_code_width = 8;
    localparam logic [int_code_width-1:0] timer_int_code = 8'd7;

    // cache line geometry
    localparam int line_words     = 4;
    localparam int line_width     = line_words * xlen;
    localparam int beat_cnt_width = 2;

    typedef enum logic [1:0] {
        region_none,
        region_timer,
        region_int,
        region_io
    } region_e;

    typedef enum logic [1:0] {
        acc_idle,
        acc_wait,
        acc_done
    } access_state_e;

    typedef enum logic [1:0] {
        port_idle,
        port_single,
        port_line,
        port_finish
    } port_state_e;

endpackage

/* logic/data_access_ctrl.sv */
// ######################################################################
// cpu data access sequencer: decodes the target region, hands I/O
// accesses to the port controller and returns read data and completion
// ######################################################################
`timescale 1ns/1ps

module data_access_ctrl
    import sys_bus_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            read_en,
    input  logic            write_en,
    input  logic [xlen-1:0] mem_addr,
    input  logic [xlen-1:0] wdata,
    input  logic [xlen-1:0] clint_rdata,
    input  logic [xlen-1:0] io_rdata,
    input  logic            io_done,
    output logic            timer_sel,
    output logic            int_sel,
    output logic            io_req,
    output logic [xlen-1:0] rdata,
    output logic            mem_ready
);

    access_state_e   state;
    region_e         region_q;
    region_e         target;
    logic [xlen-1:0] io_data_q;

    // address decode, anything outside timer and interrupt goes to I/O
    always_comb begin
        if (mem_addr >= timer_base && mem_addr <= timer_end) begin
            target = region_timer;
        end else if (mem_addr >= int_base && mem_addr <= int_end) begin
            target = region_int;
        end else begin
            target = region_io;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= acc_idle;
            region_q <= region_none;
        end else begin
            unique case (state)
                acc_idle: begin
                    if (read_en || write_en) begin
                        region_q <= target;
                        // local regions answer after one cycle
                        state    <= (target == region_io) ? acc_wait : acc_done;
                    end
                end
                acc_wait: begin
                    if (io_done) begin
                        state <= acc_done;
                    end
                end
                acc_done: begin
                    state    <= acc_idle;
                    region_q <= region_none;
                end
                default: begin
                    state    <= acc_idle;
                    region_q <= region_none;
                end
            endcase
        end
    end

    // io_rdata is only valid with the ready beat, keep it for mem_ready
    always_ff @(posedge clk) begin
        if (io_done) begin
            io_data_q <= io_rdata;
        end
    end

    assign io_req    = (state == acc_wait);
    assign mem_ready = (state == acc_done);
    // clint acts in the done cycle while the cpu still holds the request
    assign timer_sel = (state == acc_done) && (region_q == region_timer);
    assign int_sel   = (state == acc_done) && (region_q == region_int);

    always_comb begin
        unique case (region_q)
            region_timer: rdata = clint_rdata;
            region_int:   rdata = clint_rdata;
            region_io:    rdata = io_data_q;
            default:      rdata = '0;
        endcase
    end

    a_mem_ready_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) mem_ready |=> !mem_ready);

    a_io_req_region: assert property (
        @(posedge clk) disable iff (!rst_n) io_req |-> (region_q == region_io));

    // the port controller samples address and data straight from the cpu
    a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == acc_wait) |-> $stable(mem_addr) && (!write_en || $stable(wdata)));

endmodule

/* logic/clint.sv */
// ######################################################################
// machine timer block: free running mtime, 64-bit compare, timer
// interrupt level and the current interrupt code register
// ######################################################################
`timescale 1ns/1ps

module clint
    import sys_bus_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      timer_sel,
    input  logic                      int_sel,
    input  logic                      read_en,
    input  logic                      write_en,
    input  logic [3:0]                mem_addr,
    input  logic [xlen-1:0]           wdata,
    input  logic [int_code_width-1:0] peripheral_int_code,
    output logic [xlen-1:0]           clint_rdata,
    output logic                      timer_irq
);

    logic [2*xlen-1:0]         mtime;
    logic [2*xlen-1:0]         mtimecmp;
    logic [int_code_width-1:0] cur_int_code;

    // mtime counts clk cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    // compare halves, write only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= '1;
        end else if (timer_sel && write_en) begin
            case (mem_addr)
                off_cmp_lo: begin
                    mtimecmp[xlen-1:0] <= wdata;
                end
                off_cmp_hi: begin
                    mtimecmp[2*xlen-1:xlen] <= wdata;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);
        end
    end

    // timer interrupt wins over the peripheral code
    assign cur_int_code = timer_irq ? timer_int_code : peripheral_int_code;

    // unsupported offsets read as zero
    always_comb begin
        clint_rdata = '0;
        if (timer_sel && read_en) begin
            case (mem_addr)
                off_mtime_lo: clint_rdata = mtime[xlen-1:0];
                off_mtime_hi: clint_rdata = mtime[2*xlen-1:xlen];
                default:      clint_rdata = '0;
            endcase
        end else if (int_sel && read_en && mem_addr == off_int_code) begin
            clint_rdata = {{(xlen - int_code_width){1'b0}}, cur_int_code};
        end
    end

    a_one_region: assert property (
        @(posedge clk) disable iff (!rst_n) !(timer_sel && int_sel));

endmodule

/* logic/io_port_ctrl.sv */
// ######################################################################
// external I/O port sequencer: single word cpu accesses and four-beat
// cache line bursts, a waiting line request is served first
// ######################################################################
`timescale 1ns/1ps

module io_port_ctrl
    import sys_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  io_req,
    input  logic                  read_en,
    input  logic                  write_en,
    input  logic [xlen-1:0]       mem_addr,
    input  logic [xlen-1:0]       wdata,
    input  logic [1:0]            byte_size,
    input  logic                  line_read,
    input  logic                  line_write,
    input  logic [xlen-1:0]       line_addr,
    input  logic [line_width-1:0] line_wdata,
    input  logic [xlen-1:0]       io_rdata,
    input  logic                  io_ready,
    output logic                  io_done,
    output logic [line_width-1:0] line_rdata,
    output logic                  line_ready,
    output logic [xlen-1:0]       io_addr,
    output logic                  io_read,
    output logic                  io_write,
    output logic [xlen-1:0]       io_wdata,
    output logic [1:0]            io_byte_size,
    output logic                  burst,
    output logic [2:0]            burst_size
);

    port_state_e               state;
    logic                      ready_q;
    logic                      beat_rise;
    logic                      last_beat;
    logic                      line_beat;
    logic                      start_line;
    logic                      start_single;
    logic [beat_cnt_width-1:0] beat_cnt;
    logic [beat_cnt_width-1:0] beat_next;

    // a beat is a rising edge of io_ready, a held level counts once
    assign beat_rise    = io_ready && !ready_q;
    assign last_beat    = (beat_cnt == beat_cnt_width'(line_words - 1));
    assign line_beat    = (state == port_line) && beat_rise;
    assign beat_next    = beat_cnt + 1'b1;
    assign start_line   = (state == port_idle) && (line_read || line_write);
    assign start_single = (state == port_idle) && io_req && !(line_read || line_write);

    // completion to the sequencer in the same cycle as io_ready
    assign io_done = (state == port_single) && beat_rise;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= port_idle;
            ready_q    <= 1'b0;
            io_read    <= 1'b0;
            io_write   <= 1'b0;
            burst      <= 1'b0;
            line_ready <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            ready_q    <= io_ready;
            line_ready <= 1'b0;
            unique case (state)
                port_idle: begin
                    beat_cnt <= '0;
                    if (start_line) begin
                        state    <= port_line;
                        io_read  <= line_read;
                        io_write <= line_write;
                        burst    <= 1'b1;
                    end else if (start_single) begin
                        state    <= port_single;
                        io_read  <= read_en;
                        io_write <= write_en;
                    end
                end
                port_single: begin
                    if (beat_rise) begin
                        state    <= port_finish;
                        io_read  <= 1'b0;
                        io_write <= 1'b0;
                    end
                end
                port_line: begin
                    if (beat_rise && last_beat) begin
                        state      <= port_finish;
                        io_read    <= 1'b0;
                        io_write   <= 1'b0;
                        burst      <= 1'b0;
                        line_ready <= 1'b1;
                    end else if (beat_rise) begin
                        beat_cnt <= beat_next;
                    end
                end
                // gap cycle so the requester can drop its request
                port_finish: begin
                    state <= port_idle;
                end
                default: begin
                    state <= port_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_line) begin
            io_addr      <= line_addr;
            io_wdata     <= line_wdata[xlen-1:0];
            // byte size 0 selects a full word
            io_byte_size <= 2'd0;
            burst_size   <= 3'(line_words - 1);
        end else if (start_single) begin
            io_addr      <= mem_addr;
            io_wdata     <= wdata;
            io_byte_size <= byte_size;
            burst_size   <= 3'd0;
        end else if (line_beat && !last_beat) begin
            io_addr  <= io_addr + xlen'(xlen / 8);
            io_wdata <= line_wdata[beat_next*xlen +: xlen];
        end
        // fill the line word by word on reads
        if (line_beat && io_read) begin
            line_rdata[beat_cnt*xlen +: xlen] <= io_rdata;
        end
    end

    a_rw_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(io_read && io_write));

endmodule

/* logic/sys_bus_top.sv */
// ######################################################################
// data-side system bus top: connects the cpu data port and the cache
// line channel to the timer block and the shared external I/O port
// ######################################################################
`timescale 1ns/1ps

module sys_bus_top
    import sys_bus_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    // cpu data port
    input  logic                      read_en,
    input  logic                      write_en,
    input  logic [xlen-1:0]           mem_addr,
    input  logic [xlen-1:0]           wdata,
    input  logic [1:0]                byte_size,
    output logic [xlen-1:0]           rdata,
    output logic                      mem_ready,
    // cache line channel
    input  logic                      line_read,
    input  logic                      line_write,
    input  logic [xlen-1:0]           line_addr,
    input  logic [line_width-1:0]     line_wdata,
    output logic [line_width-1:0]     line_rdata,
    output logic                      line_ready,
    // external I/O port
    output logic [xlen-1:0]           io_addr,
    output logic                      io_read,
    output logic                      io_write,
    output logic [xlen-1:0]           io_wdata,
    output logic [1:0]                io_byte_size,
    output logic                      burst,
    output logic [2:0]                burst_size,
    input  logic [xlen-1:0]           io_rdata,
    input  logic                      io_ready,
    // interrupts
    input  logic [int_code_width-1:0] peripheral_int_code,
    output logic                      timer_irq
);

    logic            timer_sel;
    logic            int_sel;
    logic            io_req;
    logic            io_done;
    logic [xlen-1:0] clint_rdata;

    data_access_ctrl i_data_access_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .read_en     (read_en),
        .write_en    (write_en),
        .mem_addr    (mem_addr),
        .wdata       (wdata),
        .clint_rdata (clint_rdata),
        .io_rdata    (io_rdata),
        .io_done     (io_done),
        .timer_sel   (timer_sel),
        .int_sel     (int_sel),
        .io_req      (io_req),
        .rdata       (rdata),
        .mem_ready   (mem_ready)
    );

    // only the register offset reaches the timer block
    clint i_clint (
        .clk                 (clk),
        .rst_n               (rst_n),
        .timer_sel           (timer_sel),
        .int_sel             (int_sel),
        .read_en             (read_en),
        .write_en            (write_en),
        .mem_addr            (mem_addr[3:0]),
        .wdata               (wdata),
        .peripheral_int_code (peripheral_int_code),
        .clint_rdata         (clint_rdata),
        .timer_irq           (timer_irq)
    );

    io_port_ctrl i_io_port_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .io_req       (io_req),
        .read_en      (read_en),
        .write_en     (write_en),
        .mem_addr     (mem_addr),
        .wdata        (wdata),
        .byte_size    (byte_size),
        .line_read    (line_read),
        .line_write   (line_write),
        .line_addr    (line_addr),
        .line_wdata   (line_wdata),
        .io_rdata     (io_rdata),
        .io_ready     (io_ready),
        .io_done      (io_done),
        .line_rdata   (line_rdata),
        .line_ready   (line_ready),
        .io_addr      (io_addr),
        .io_read      (io_read),
        .io_write     (io_write),
        .io_wdata     (io_wdata),
        .io_byte_size (io_byte_size),
        .burst        (burst),
        .burst_size   (burst_size)
    );

endmodule

/* sim/io_slave_model.sv */
// ######################################################################
// word memory behind the external I/O port, answers each beat with a
// one-cycle io_ready pulse after a delay taken from the delay input
// ######################################################################
`timescale 1ns/1ps

module io_slave_model
    import sys_bus_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic [xlen-1:0] io_addr,
    input  logic            io_read,
    input  logic            io_write,
    input  logic [xlen-1:0] io_wdata,
    input  logic [2:0]      delay,
    output logic [xlen-1:0] io_rdata,
    output logic            io_ready
);

    logic [xlen-1:0] mem [0:63];
    logic [2:0]      wait_cnt;
    logic            busy;
    logic            beat;

    // fill pattern covers every index bit
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = (32'(i) * 32'h0001_0003) ^ 32'h5a5a_0000;
        end
    end

    assign beat = busy && (wait_cnt == 3'd0) && !io_ready;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            io_ready <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= 3'd0;
        end else begin
            io_ready <= 1'b0;
            if (io_ready) begin
                // one low cycle between beats so each beat is a fresh edge
                busy <= 1'b0;
            end else if (!busy && (io_read || io_write)) begin
                busy     <= 1'b1;
                wait_cnt <= delay;
            end else if (busy && wait_cnt != 3'd0) begin
                wait_cnt <= wait_cnt - 3'd1;
            end else if (beat) begin
                io_ready <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (beat) begin
            io_rdata <= mem[io_addr[7:2]];
            if (io_write) begin
                mem[io_addr[7:2]] <= io_wdata;
            end
        end
    end

endmodule

/* sim/tb_sys_bus.sv */
// ######################################################################
// testbench for the data-side system bus: runs a table of cpu and line
// accesses against the timer block and a slave memory on the I/O port
// ######################################################################
`timescale 1ns/1ps

module tb_sys_bus
    import sys_bus_pkg::*;
();

    typedef enum logic [1:0] {cpu_rd, cpu_wr, line_rd, line_wr} kind_e;
    typedef enum logic [1:0] {chk_none, chk_exact, chk_incr, chk_code} chk_e;

    typedef struct packed {
        kind_e                 kind;
        chk_e                  chk;
        logic                  overlap;
        logic [xlen-1:0]       addr;
        logic [line_width-1:0] data;
        logic [line_width-1:0] expd;
    } test_t;

    localparam logic [xlen-1:0] mtime_lo_a = timer_base + 32'(off_mtime_lo);
    localparam logic [xlen-1:0] cmp_lo_a   = timer_base + 32'(off_cmp_lo);
    localparam logic [xlen-1:0] cmp_hi_a   = timer_base + 32'(off_cmp_hi);
    localparam logic [xlen-1:0] int_code_a = int_base + 32'(off_int_code);
    localparam logic [xlen-1:0] io_base    = 32'h8000_0000;

    logic                      clk;
    logic                      rst_n;
    logic                      read_en;
    logic                      write_en;
    logic [xlen-1:0]           mem_addr;
    logic [xlen-1:0]           wdata;
    logic [1:0]                byte_size;
    logic [xlen-1:0]           rdata;
    logic                      mem_ready;
    logic                      line_read;
    logic                      line_write;
    logic [xlen-1:0]           line_addr;
    logic [line_width-1:0]     line_wdata;
    logic [line_width-1:0]     line_rdata;
    logic                      line_ready;
    logic [xlen-1:0]           io_addr;
    logic                      io_read;
    logic                      io_write;
    logic [xlen-1:0]           io_wdata;
    logic [1:0]                io_byte_size;
    logic                      burst;
    logic [2:0]                burst_size;
    logic [xlen-1:0]           io_rdata;
    logic                      io_ready;
    logic [int_code_width-1:0] peripheral_int_code;
    logic                      timer_irq;
    logic [2:0]                slave_delay;

    test_t           tests[$];
    logic [31:0]     lfsr;
    logic [xlen-1:0] last_mtime;
    int              errors;
    int              tests_done;

    sys_bus_top i_sys_bus_top (.*);

    io_slave_model i_io_slave_model (
        .clk      (clk),
        .rst_n    (rst_n),
        .io_addr  (io_addr),
        .io_read  (io_read),
        .io_write (io_write),
        .io_wdata (io_wdata),
        .delay    (slave_delay),
        .io_rdata (io_rdata),
        .io_ready (io_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
    endtask

    task automatic check_value(input string what, input logic [line_width-1:0] got,
                               input logic [line_width-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic add_entry(input kind_e kind, input chk_e chk, input logic overlap,
                             input logic [xlen-1:0] addr, input logic [line_width-1:0] data,
                             input logic [line_width-1:0] expd);
        test_t t;
        t.kind    = kind;
        t.chk     = chk;
        t.overlap = overlap;
        t.addr    = addr;
        t.data    = data;
        t.expd    = expd;
        tests.push_back(t);
    endtask

    task automatic build_table();
        logic [31:0]           w;
        logic [xlen-1:0]       io_words [3];
        logic [line_width-1:0] line;
        logic [line_width-1:0] line2;
        // timer and interrupt code
        add_entry(cpu_rd, chk_incr, 1'b0, mtime_lo_a, '0, '0);
        add_entry(cpu_rd, chk_incr, 1'b0, mtime_lo_a, '0, '0);
        add_entry(cpu_rd, chk_code, 1'b0, int_code_a, '0, 128'h2c);
        add_entry(cpu_wr, chk_none, 1'b0, cmp_hi_a, '0, '0);
        add_entry(cpu_wr, chk_none, 1'b0, cmp_lo_a, '0, '0);
        add_entry(cpu_rd, chk_code, 1'b0, int_code_a, '0, 128'h7);
        // mtime is read only
        add_entry(cpu_wr, chk_none, 1'b0, mtime_lo_a, '0, '0);
        add_entry(cpu_rd, chk_incr, 1'b0, mtime_lo_a, '0, '0);
        // single words
        for (int k = 0; k < 3; k++) begin
            take_bits(32, w);
            io_words[k] = w;
            add_entry(cpu_wr, chk_none, 1'b0, io_base + 32'(16 + 20 * k), {96'h0, w}, '0);
        end
        for (int k = 0; k < 3; k++) begin
            add_entry(cpu_rd, chk_exact, 1'b0, io_base + 32'(16 + 20 * k), '0,
                      {96'h0, io_words[k]});
        end
        // line burst followed by the same line word by word
        for (int k = 0; k < line_words; k++) begin
            take_bits(32, w);
            line[k*xlen +: xlen] = w;
        end
        add_entry(line_wr, chk_none, 1'b0, io_base + 32'h40, line, '0);
        add_entry(line_rd, chk_exact, 1'b0, io_base + 32'h40, '0, line);
        for (int k = 0; k < line_words; k++) begin
            add_entry(cpu_rd, chk_exact, 1'b0, io_base + 32'h40 + 32'(4 * k), '0,
                      {96'h0, line[k*xlen +: xlen]});
        end
        // line and cpu raised together
        add_entry(line_rd, chk_exact, 1'b1, io_base + 32'h40, '0, line);
        add_entry(cpu_rd, chk_exact, 1'b0, io_base + 32'h10, '0, {96'h0, io_words[0]});
        for (int k = 0; k < line_words; k++) begin
            take_bits(32, w);
            line2[k*xlen +: xlen] = w;
        end
        take_bits(32, w);
        add_entry(line_wr, chk_none, 1'b1, io_base + 32'h80, line2, '0);
        add_entry(cpu_wr, chk_none, 1'b0, io_base + 32'h10, {96'h0, w}, '0);
        add_entry(line_rd, chk_exact, 1'b1, io_base + 32'h80, '0, line2);
        add_entry(cpu_rd, chk_exact, 1'b0, io_base + 32'h10, '0, {96'h0, w});
    endtask

    task automatic cpu_access(input logic wr, input logic [xlen-1:0] addr,
                              input logic [xlen-1:0] d, output logic [xlen-1:0] got);
        @(posedge clk);
        read_en   <= !wr;
        write_en  <= wr;
        mem_addr  <= addr;
        wdata     <= d;
        byte_size <= 2'd0;
        do @(posedge clk); while (!mem_ready);
        got = rdata;
        read_en  <= 1'b0;
        write_en <= 1'b0;
    endtask

    task automatic line_access(input logic wr, input logic [xlen-1:0] addr,
                               input logic [line_width-1:0] d,
                               output logic [line_width-1:0] got);
        int beats;
        @(posedge clk);
        line_read  <= !wr;
        line_write <= wr;
        line_addr  <= addr;
        line_wdata <= d;
        beats = 0;
        do begin
            @(posedge clk);
            // only beats with burst high belong to the line
            if (io_ready && burst) begin
                check_value("burst address", 128'(io_addr), 128'(addr + 32'(4 * beats)));
                check_value("burst size", 128'(burst_size), 128'(line_words - 1));
                check_value("burst byte size", 128'(io_byte_size), 128'(0));
                beats++;
            end
        end while (!line_ready);
        got = line_rdata;
        line_read  <= 1'b0;
        line_write <= 1'b0;
        check_value("line beat count", 128'(beats), 128'(line_words));
    endtask

    task automatic run_entry(input int idx);
        test_t                 t;
        kind_e                 kind;
        logic [xlen-1:0]       word;
        logic [line_width-1:0] got;
        int                    errs_before;
        t           = tests[idx];
        kind        = t.kind;
        errs_before = errors;
        got         = '0;
        case (kind)
            cpu_rd: begin
                cpu_access(1'b0, t.addr, 32'h0, word);
                got = {96'h0, word};
            end
            cpu_wr:  cpu_access(1'b1, t.addr, t.data[xlen-1:0], word);
            line_rd: line_access(1'b0, t.addr, '0, got);
            default: line_access(1'b1, t.addr, t.data, got);
        endcase
        if (t.chk == chk_exact || t.chk == chk_code) begin
            check_value($sformatf("test %0d", idx), got, t.expd);
        end else if (t.chk == chk_incr) begin
            check_value($sformatf("test %0d mtime step", idx),
                        {127'h0, got[xlen-1:0] > last_mtime}, 128'h1);
            last_mtime = got[xlen-1:0];
        end
        if (t.chk == chk_code) begin
            // the timer code is reported exactly while timer_irq is high
            check_value($sformatf("test %0d timer_irq", idx), {127'h0, timer_irq},
                        {127'h0, t.expd == 128'(timer_int_code)});
        end
        tests_done++;
        $display("test %0d %s at %h: %s", idx, kind.name(), t.addr,
                 (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int i;
        rst_n               = 1'b0;
        read_en             = 1'b0;
        write_en            = 1'b0;
        mem_addr            = '0;
        wdata               = '0;
        byte_size           = 2'd0;
        line_read           = 1'b0;
        line_write          = 1'b0;
        line_addr           = '0;
        line_wdata          = '0;
        peripheral_int_code = 8'h2c;
        slave_delay         = 3'd0;
        lfsr                = 32'h40d8_84db;
        last_mtime          = '0;
        errors              = 0;
        tests_done          = 0;
        build_table();
        // new slave delay every cycle
        fork
            forever begin
                logic [31:0] b;
                @(posedge clk);
                take_bits(3, b);
                slave_delay <= b[2:0];
            end
        join_none
        repeat (10) @(posedge clk);
        check_value("outputs in reset",
                    {122'h0, mem_ready, line_ready, io_read, io_write, burst, timer_irq}, '0);
        rst_n <= 1'b1;
        i = 0;
        while (i < tests.size()) begin
            if (tests[i].overlap && i + 1 < tests.size()) begin
                fork
                    run_entry(i);
                    run_entry(i + 1);
                join
                i += 2;
            end else begin
                run_entry(i);
                i++;
            end
        end
        $display("%0d tests run, %0d errors", tests_done, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog covers 64 cycles per table entry plus reset
    initial begin
        #1;
        repeat (tests.size() * 64 + 20) @(posedge clk);
        $display("watchdog expired, the test table did not complete in time");
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* vlog.f */
logic/sys_bus_pkg.sv
logic/data_access_ctrl.sv
logic/clint.sv
logic/io_port_ctrl.sv
logic/sys_bus_top.sv
sim/io_slave_model.sv
sim/tb_sys_bus.sv

/* Makefile */
SIM_BIN := obj_dir/Vtb_sys_bus

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): vlog.f $(wildcard logic/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module tb_sys_bus

run: $(SIM_BIN)
	./$(SIM_BIN) > sim.log 2>&1; cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
